// ==== common/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte RAM geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One RAM location
    localparam int byte_width = 8;

    // Total storage in bytes
    localparam int mem_bytes = 64;

    // Enough bits to reach every byte
    localparam int mem_addr_width = $clog2(mem_bytes);

endpackage

`default_nettype wire

// ==== common/stack_pkg.sv ====
`default_nettype none

package stack_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int word_width = 32;
    localparam int bytes_per_word = 4;

    // Capacity follows from the byte RAM size
    localparam int stack_words = mem_pkg::mem_bytes / bytes_per_word;

    // Depth counts 0 through stack_words inclusive
    localparam int depth_width = $clog2(stack_words + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host operations and FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [0:0] {
        op_push = 1'b0,
        op_pop  = 1'b1
    } stack_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_read_addr,
        st_read_data,
        st_done
    } stack_state_e;

endpackage

`default_nettype wire

// ==== common/byte_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface byte_mem_if;
    import mem_pkg::*;

    // Write strobe, sampled at the clock edge
    logic we;
    logic [mem_addr_width-1:0] addr;
    logic [byte_width-1:0] wbyte;

    // Registered read data, one cycle behind addr
    logic [byte_width-1:0] rbyte;

    modport ctrl (
        output we,
        output addr,
        output wbyte,
        input  rbyte
    );

    modport mem (
        input  we,
        input  addr,
        input  wbyte,
        output rbyte
    );

endinterface

`default_nettype wire

// ==== stack/byte_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_ram (
    input logic clk,
    byte_mem_if.mem mem
);
    import mem_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [byte_width-1:0] ram [mem_bytes];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.wbyte;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Read-first, so the old byte comes out during a write
    always_ff @(posedge clk) begin
        mem.rbyte <= ram[mem.addr];
    end

endmodule

`default_nettype wire

// ==== stack/word_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_stack (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  stack_pkg::stack_op_e                op,
    input  logic [stack_pkg::word_width-1:0]    wdata,
    output logic                                ack,
    output logic                                err,
    output logic [stack_pkg::word_width-1:0]    rdata,
    output logic [stack_pkg::depth_width-1:0]   depth
);
    import stack_pkg::*;
    import mem_pkg::*;

    stack_state_e state;

    // Byte address of the first free location
    logic [mem_addr_width-1:0] top;

    // Byte index within the current word
    logic [1:0] cnt;

    logic full;
    logic empty;
    logic reject;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte RAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    byte_mem_if mem_bus ();

    byte_ram u_ram (
        .clk (clk),
        .mem (mem_bus.mem)
    );

    // Push writes upward from top, low byte first
    // Pop reads downward from top-1, high byte first
    assign mem_bus.we    = (state == st_write);
    assign mem_bus.wbyte = wdata[byte_width*cnt +: byte_width];
    assign mem_bus.addr  = (state == st_write)
                         ? top + mem_addr_width'(cnt)
                         : top - mem_addr_width'(cnt) - mem_addr_width'(1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign full   = (depth == depth_width'(stack_words));
    assign empty  = (depth == '0);
    assign reject = (op == op_push) ? full : empty;

    // Held for as long as the host keeps req high
    assign ack = (state == st_done);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            top   <= '0;
            cnt   <= '0;
            depth <= '0;
            err   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        cnt <= '0;
                        if (reject) begin
                            // No memory traffic on a rejected request
                            err   <= 1'b1;
                            state <= st_done;
                        end else if (op == op_push) begin
                            state <= st_write;
                        end else begin
                            state <= st_read_addr;
                        end
                    end
                end

                st_write: begin
                    cnt <= cnt + 2'd1;
                    if (cnt == 2'd3) begin
                        top   <= top + mem_addr_width'(bytes_per_word);
                        depth <= depth + depth_width'(1);
                        state <= st_done;
                    end
                end

                st_read_addr: begin
                    state <= st_read_data;
                end

                st_read_data: begin
                    cnt <= cnt + 2'd1;
                    if (cnt == 2'd3) begin
                        top   <= top - mem_addr_width'(bytes_per_word);
                        depth <= depth - depth_width'(1);
                        state <= st_done;
                    end else begin
                        state <= st_read_addr;
                    end
                end

                st_done: begin
                    // Four-phase release
                    if (!req) begin
                        err   <= 1'b0;
                        state <= st_idle;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pop word assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // First byte returned ends up in the top lane
    always_ff @(posedge clk) begin
        if (state == st_read_data) begin
            rdata <= {rdata[word_width-byte_width-1:0], mem_bus.rbyte};
        end
    end

endmodule

`default_nettype wire

// ==== logic/stack_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  stack_pkg::stack_op_e                op,
    input  logic [stack_pkg::word_width-1:0]    wdata,
    output logic                                ack,
    output logic                                err,
    output logic [stack_pkg::word_width-1:0]    rdata,
    output logic [stack_pkg::depth_width-1:0]   depth
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stack controller with its RAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    word_stack u_stack (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .wdata (wdata),
        .ack   (ack),
        .err   (err),
        .rdata (rdata),
        .depth (depth)
    );

endmodule

`default_nettype wire

// ==== dv/stack_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_checker (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 req,
    input logic                                 ack,
    input logic                                 err,
    input logic                                 we,
    input stack_pkg::stack_state_e              state,
    input logic [stack_pkg::depth_width-1:0]    depth
);
    import stack_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Host may already have dropped req when the rise is sampled
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack)
        else $error("ack fell while req was still high");

    err_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
        err |-> ack)
        else $error("err high without ack");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A push writes four bytes back to back, then acknowledges
    we_burst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(we) |-> ##4 (state == st_done))
        else $error("RAM write burst not four cycles long");

    depth_bound: assert property (@(posedge clk) disable iff (!rst_n)
        depth <= depth_width'(stack_words))
        else $error("depth above stack capacity");

endmodule

bind word_stack stack_checker u_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .err   (err),
    .we    (mem_bus.we),
    .state (state),
    .depth (depth)
);

`default_nettype wire

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import stack_pkg::*;

    localparam int reset_cycles = 8;
    // 10 + 1 + 33 + 400 + at most 48 for the byte lane test
    localparam int total_ops = 492;
    localparam int cycles_per_op = 12;
    localparam int cycle_limit = total_ops * cycles_per_op + reset_cycles + 500;

    logic clk;
    logic rst_n;
    logic req;
    stack_op_e op;
    logic [word_width-1:0] wdata;
    logic ack;
    logic err;
    logic [word_width-1:0] rdata;
    logic [depth_width-1:0] depth;

    // Reference stack, back of the queue is top of stack
    logic [word_width-1:0] model_q[$];

    string test_name;
    int test_errs;
    int total_errs;
    int tests_run;
    int tests_failed;
    int cycle_count = 0;

    stack_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .wdata (wdata),
        .ack   (ack),
        .err   (err),
        .rdata (rdata),
        .depth (depth)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped: cycle limit of %0d reached before the tests ended",
                     cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bookkeeping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d mismatches", test_name, test_errs);
        end
    endtask

    task automatic mismatch(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        test_errs++;
        total_errs++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One four-phase transaction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic transfer(input stack_op_e o, input logic [word_width-1:0] d);
        logic got_err;
        logic [word_width-1:0] got_data;
        logic [depth_width-1:0] got_depth;
        logic exp_err;
        logic [word_width-1:0] exp_data;
        req = 1'b1;
        op = o;
        wdata = d;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        got_err = err;
        got_data = rdata;
        got_depth = depth;
        req = 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end

        exp_data = '0;
        if (o == op_push) begin
            exp_err = (model_q.size() >= stack_words);
            if (!exp_err) model_q.push_back(d);
        end else begin
            exp_err = (model_q.size() == 0);
            if (!exp_err) exp_data = model_q.pop_back();
        end

        if (got_err != exp_err) mismatch("err", 32'(exp_err), 32'(got_err));
        if (o == op_pop && !exp_err && got_data != exp_data) begin
            mismatch("rdata", exp_data, got_data);
        end
        if (got_depth != depth_width'(model_q.size())) begin
            mismatch("depth", model_q.size(), 32'(got_depth));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [7:0] r;
        void'($urandom(97962));
        rst_n = 1'b0;
        req = 1'b0;
        op = op_push;
        wdata = '0;
        total_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        begin_test("reset_state");
        if (ack !== 1'b0) mismatch("ack", 0, 32'(ack));
        if (err !== 1'b0) mismatch("err", 0, 32'(err));
        if (depth !== '0) mismatch("depth", 0, 32'(depth));
        end_test();

        begin_test("push_pop_order");
        for (int i = 0; i < 5; i++) transfer(op_push, $urandom());
        for (int i = 0; i < 5; i++) transfer(op_pop, '0);
        end_test();

        begin_test("underflow");
        transfer(op_pop, '0);
        end_test();

        // One push past capacity, then drain in LIFO order
        begin_test("overflow");
        for (int i = 0; i < stack_words; i++) transfer(op_push, $urandom());
        transfer(op_push, $urandom());
        for (int i = 0; i < stack_words; i++) transfer(op_pop, '0);
        end_test();

        begin_test("random_mix");
        for (int i = 0; i < 400; i++) begin
            if ($urandom_range(0, 1) == 0) begin
                transfer(op_push, $urandom());
            end else begin
                transfer(op_pop, '0);
            end
        end
        end_test();

        begin_test("byte_order");
        while (model_q.size() > 0) transfer(op_pop, '0);
        for (int i = 0; i < 8; i++) begin
            r = 8'($urandom());
            // Four distinct byte lanes
            transfer(op_push, {r + 8'hc3, r + 8'h82, r + 8'h41, r});
            transfer(op_push, $urandom());
            transfer(op_pop, '0);
        end
        for (int i = 0; i < 8; i++) transfer(op_pop, '0);
        end_test();

        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d mismatches",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/mem_pkg.sv
common/stack_pkg.sv
common/byte_mem_if.sv
stack/byte_ram.sv
stack/word_stack.sv
logic/stack_top.sv
dv/stack_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
